/* decoderPkg.sv */
package decoderPkg;

        typedef logic [31:0] instr_t;

        ////////////////////////////////////////
        // Opcode field, bits 31:26

        localparam logic [5:0] OP_SPECIAL  = 6'b000000;
        localparam logic [5:0] OP_SPECIAL2 = 6'b011100;  // MUL and MADD family
        localparam logic [5:0] OP_SPECIAL3 = 6'b011111;
        localparam logic [5:0] OP_ADDI     = 6'b001000;
        localparam logic [5:0] OP_ADDIU    = 6'b001001;
        localparam logic [5:0] OP_SLTI     = 6'b001010;
        localparam logic [5:0] OP_SLTIU    = 6'b001011;
        localparam logic [5:0] OP_ANDI     = 6'b001100;
        localparam logic [5:0] OP_ORI      = 6'b001101;
        localparam logic [5:0] OP_XORI     = 6'b001110;
        localparam logic [5:0] OP_LUI      = 6'b001111;
        localparam logic [5:0] OP_LW       = 6'b100011;
        localparam logic [5:0] OP_LH       = 6'b100001;
        localparam logic [5:0] OP_LB       = 6'b100000;
        localparam logic [5:0] OP_SW       = 6'b101011;
        localparam logic [5:0] OP_SH       = 6'b101001;
        localparam logic [5:0] OP_SB       = 6'b101000;

        ////////////////////////////////////////
        // Function field, bits 5:0

        localparam logic [5:0] FN_ADD   = 6'b100000;
        localparam logic [5:0] FN_ADDU  = 6'b100001;
        localparam logic [5:0] FN_SUB   = 6'b100010;
        localparam logic [5:0] FN_AND   = 6'b100100;
        localparam logic [5:0] FN_OR    = 6'b100101;
        localparam logic [5:0] FN_NOR   = 6'b100111;
        localparam logic [5:0] FN_XOR   = 6'b100110;
        localparam logic [5:0] FN_SLT   = 6'b101010;
        localparam logic [5:0] FN_SLTU  = 6'b101011;
        localparam logic [5:0] FN_SLL   = 6'b000000;
        localparam logic [5:0] FN_SRL   = 6'b000010;  // ROTR when bit 21 set
        localparam logic [5:0] FN_SRA   = 6'b000011;
        localparam logic [5:0] FN_SLLV  = 6'b000100;
        localparam logic [5:0] FN_SRLV  = 6'b000110;  // ROTRV when bit 6 set
        localparam logic [5:0] FN_SRAV  = 6'b000111;
        localparam logic [5:0] FN_BSHFL = 6'b100000;  // SPECIAL3 byte shuffle group
        localparam logic [5:0] FN_MOVN  = 6'b001011;
        localparam logic [5:0] FN_MOVZ  = 6'b001010;

        localparam logic [4:0] SP_SEB = 5'b10000;
        localparam logic [4:0] SP_SEH = 5'b11000;

        ////////////////////////////////////////
        // Control word

        typedef enum logic [5:0] {
                ALU_ADD  = 6'b000000,
                ALU_SUB  = 6'b000001,
                ALU_AND  = 6'b000010,
                ALU_OR   = 6'b000011,
                ALU_NOR  = 6'b000100,
                ALU_XOR  = 6'b000101,
                ALU_SEH  = 6'b000110,
                ALU_SLL  = 6'b000111,
                ALU_SRL  = 6'b001000,
                ALU_SLT  = 6'b001001,
                ALU_MOVN = 6'b001010,
                ALU_MOVZ = 6'b001011,
                ALU_ROTR = 6'b001100,
                ALU_SRA  = 6'b001101,
                ALU_SEB  = 6'b001111,
                ALU_SLTU = 6'b010001,
                ALU_ADDU = 6'b010111,
                ALU_LUI  = 6'b100001,
                ALU_ADDR = 6'b100100   // Load and store address
        } aluOp_t;

        typedef enum logic [1:0] {
                MEM_NONE = 2'b00,
                MEM_WORD = 2'b01,
                MEM_HALF = 2'b10,
                MEM_BYTE = 2'b11
        } memAccess_t;

        typedef struct packed {
                logic       regWrite;
                logic       regDst;      // 1 writes rd
                logic       shamtSrcA;
                logic       immSrcB;
                logic       zeroExtImm;
                memAccess_t memRead;
                memAccess_t memWrite;
                logic       memToReg;    // 1 takes the ALU result
                aluOp_t     aluOp;
                logic       illegal;
        } ctrlWord_t;

        localparam ctrlWord_t CTRL_IDLE = '{
                regWrite:   1'b0,
                regDst:     1'b0,
                shamtSrcA:  1'b0,
                immSrcB:    1'b0,
                zeroExtImm: 1'b0,
                memRead:    MEM_NONE,
                memWrite:   MEM_NONE,
                memToReg:   1'b1,
                aluOp:      ALU_ADD,
                illegal:    1'b0
        };

        localparam int IN_DEPTH    = 4;   // Also upstream credits after reset
        localparam int OUT_CREDITS = 4;
        localparam int OUT_DEPTH   = 4;

endpackage

/* creditFifo.sv */
`timescale 1ns/1ps

module creditFifo
#(
        parameter type payload_t = logic [31:0],
        parameter int  DEPTH     = 4
)
(
        input  logic     clk,
        input  logic     rst,
        input  logic     push,
        input  payload_t wrData,
        input  logic     pop,
        output payload_t rdData,
        output logic     empty,
        output logic     full
);

        typedef logic [$clog2(DEPTH)-1:0]     ptr_t;
        typedef logic [$clog2(DEPTH + 1)-1:0] count_t;

        payload_t mem [DEPTH];
        ptr_t     wrPtr;
        ptr_t     rdPtr;
        count_t   count;

        function automatic ptr_t nextPtr(input ptr_t ptr);
                if (ptr == ptr_t'(DEPTH - 1))
                        return '0;
                return ptr + 1'b1;
        endfunction

        always_ff @(posedge clk)
        begin
                if (push)
                        mem[wrPtr] <= wrData;
        end

        always_ff @(posedge clk)
        begin
                if (rst)
                begin
                        wrPtr <= '0;
                        rdPtr <= '0;
                        count <= '0;
                end
                else
                begin
                        if (push)
                                wrPtr <= nextPtr(wrPtr);
                        if (pop)
                                rdPtr <= nextPtr(rdPtr);
                        case ({push, pop})
                                2'b10:   count <= count + 1'b1;
                                2'b01:   count <= count - 1'b1;
                                default: count <= count;   // Idle or pass through
                        endcase
                end
        end

        // Head entry shown without a register stage
        assign rdData = mem[rdPtr];
        assign empty  = (count == '0);
        assign full   = (count == count_t'(DEPTH));

endmodule

/* instrDecoder.sv */
`timescale 1ns/1ps

module instrDecoder
        import decoderPkg::*;
(
        input  instr_t    instr,
        output ctrlWord_t ctrl
);

        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [4:0] special3Op;
        logic [5:0] funct;
        logic       isNop;

        assign opcode     = instr[31:26];
        assign rs         = instr[25:21];
        assign rt         = instr[20:16];
        assign rd         = instr[15:11];
        assign shamt      = instr[10:6];
        assign special3Op = instr[10:6];   // Shares bits with shamt
        assign funct      = instr[5:0];

        // All-zero word, which would otherwise read as SLL
        assign isNop = (opcode == OP_SPECIAL) && (rs == '0) && (rt == '0) && (rd == '0)
                       && (shamt == '0) && (funct == FN_SLL);

        function automatic memAccess_t accessSize(input logic [1:0] sizeBits);
                case (sizeBits)
                        2'b11:   return MEM_WORD;
                        2'b01:   return MEM_HALF;
                        default: return MEM_BYTE;
                endcase
        endfunction

        function automatic aluOp_t immAluOp(input logic [5:0] op);
                case (op)
                        OP_ADDIU: return ALU_ADDU;
                        OP_SLTI:  return ALU_SLT;
                        OP_SLTIU: return ALU_SLTU;
                        OP_ANDI:  return ALU_AND;
                        OP_ORI:   return ALU_OR;
                        OP_XORI:  return ALU_XOR;
                        OP_LUI:   return ALU_LUI;
                        default:  return ALU_ADD;   // ADDI
                endcase
        endfunction

        always_comb
        begin
                ctrl = CTRL_IDLE;
                if (!isNop)
                begin
                        case (opcode)
                                ////////////////////////////////////////
                                // Register forms
                                OP_SPECIAL:
                                begin
                                        ctrl.regWrite = 1'b1;
                                        ctrl.regDst   = 1'b1;
                                        case (funct)
                                                FN_ADD:  ctrl.aluOp = ALU_ADD;
                                                FN_ADDU: ctrl.aluOp = ALU_ADDU;
                                                FN_SUB:  ctrl.aluOp = ALU_SUB;
                                                FN_AND:  ctrl.aluOp = ALU_AND;
                                                FN_OR:   ctrl.aluOp = ALU_OR;
                                                FN_NOR:  ctrl.aluOp = ALU_NOR;
                                                FN_XOR:  ctrl.aluOp = ALU_XOR;
                                                FN_SLT:  ctrl.aluOp = ALU_SLT;
                                                FN_SLTU: ctrl.aluOp = ALU_SLTU;
                                                FN_MOVN: ctrl.aluOp = ALU_MOVN;
                                                FN_MOVZ: ctrl.aluOp = ALU_MOVZ;
                                                FN_SLL:
                                                begin
                                                        ctrl.aluOp     = ALU_SLL;
                                                        ctrl.shamtSrcA = 1'b1;
                                                end
                                                FN_SRL:
                                                begin
                                                        ctrl.aluOp     = rs[0] ? ALU_ROTR : ALU_SRL;
                                                        ctrl.shamtSrcA = 1'b1;
                                                end
                                                FN_SRA:
                                                begin
                                                        ctrl.aluOp     = ALU_SRA;
                                                        ctrl.shamtSrcA = 1'b1;
                                                end
                                                FN_SLLV: ctrl.aluOp = ALU_SLL;
                                                FN_SRLV: ctrl.aluOp = shamt[0] ? ALU_ROTR : ALU_SRL;
                                                FN_SRAV: ctrl.aluOp = ALU_SRA;
                                                default: ctrl.illegal = 1'b1;   // Jumps, HI/LO, MULT
                                        endcase
                                end
                                OP_SPECIAL3:
                                begin
                                        ctrl.regWrite = 1'b1;
                                        ctrl.regDst   = 1'b1;
                                        if (funct != FN_BSHFL)
                                                ctrl.illegal = 1'b1;
                                        else if (special3Op == SP_SEB)
                                                ctrl.aluOp = ALU_SEB;
                                        else if (special3Op == SP_SEH)
                                                ctrl.aluOp = ALU_SEH;
                                        else
                                                ctrl.illegal = 1'b1;
                                end
                                OP_SPECIAL2:
                                        ctrl.illegal = 1'b1;   // No multiplier here

                                ////////////////////////////////////////
                                // Immediate and memory forms
                                OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU:
                                begin
                                        ctrl.regWrite = 1'b1;
                                        ctrl.immSrcB  = 1'b1;
                                        ctrl.aluOp    = immAluOp(opcode);
                                end
                                OP_ANDI, OP_ORI, OP_XORI, OP_LUI:
                                begin
                                        ctrl.regWrite   = 1'b1;
                                        ctrl.immSrcB    = 1'b1;
                                        ctrl.zeroExtImm = 1'b1;
                                        ctrl.aluOp      = immAluOp(opcode);
                                end
                                OP_LW, OP_LH, OP_LB:
                                begin
                                        ctrl.regWrite = 1'b1;
                                        ctrl.immSrcB  = 1'b1;
                                        ctrl.memToReg = 1'b0;   // Load data to rt
                                        ctrl.memRead  = accessSize(opcode[1:0]);
                                        ctrl.aluOp    = ALU_ADDR;
                                end
                                OP_SW, OP_SH, OP_SB:
                                begin
                                        ctrl.immSrcB  = 1'b1;
                                        ctrl.memWrite = accessSize(opcode[1:0]);
                                        ctrl.aluOp    = ALU_ADDR;
                                end
                                default: ctrl.illegal = 1'b1;   // Branches and unused
                        endcase
                end

                if (ctrl.illegal)
                begin
                        ctrl         = CTRL_IDLE;   // Drop all enables
                        ctrl.illegal = 1'b1;
                end
        end

endmodule

/* creditSender.sv */
`timescale 1ns/1ps

module creditSender
        import decoderPkg::*;
(
        input  logic      clk,
        input  logic      rst,
        input  logic      empty,
        input  ctrlWord_t head,
        output logic      pop,
        input  logic      ctrlCredit,
        output logic      ctrlValid,
        output ctrlWord_t ctrl
);

        typedef logic [$clog2(OUT_CREDITS + 1)-1:0] credit_t;

        credit_t   credits;
        ctrlWord_t staged;
        logic      stagedValid;

        // Credit is spent when the word leaves the FIFO
        assign pop = !empty && (credits != '0);

        always_ff @(posedge clk)
        begin
                if (rst)
                begin
                        credits     <= credit_t'(OUT_CREDITS);
                        stagedValid <= 1'b0;
                        ctrlValid   <= 1'b0;
                end
                else
                begin
                        case ({pop, ctrlCredit})
                                2'b10:   credits <= credits - 1'b1;
                                2'b01:   credits <= credits + 1'b1;
                                default: credits <= credits;   // Spent and returned
                        endcase
                        stagedValid <= pop;
                        ctrlValid   <= stagedValid;
                end
        end

        ////////////////////////////////////////
        // Pop stage then output register
        always_ff @(posedge clk)
        begin
                if (pop)
                        staged <= head;
                ctrl <= staged;
        end

endmodule

/* decodeUnit.sv */
`timescale 1ns/1ps

module decodeUnit
        import decoderPkg::*;
(
        input  logic      clk,
        input  logic      rst,
        input  logic      instrValid,
        input  instr_t    instr,
        output logic      instrCredit,
        output logic      ctrlValid,
        output ctrlWord_t ctrl,
        input  logic      ctrlCredit
);

        instr_t    inHead;
        ctrlWord_t decoded;
        ctrlWord_t outHead;
        logic      inPush;
        logic      inEmpty;
        logic      inFull;
        logic      outEmpty;
        logic      outFull;
        logic      move;
        logic      outPop;

        assign inPush = instrValid && !inFull;   // Upstream holds a credit anyway
        assign move   = !inEmpty && !outFull;    // Decode and transfer in one cycle

        creditFifo #(
                .payload_t (instr_t),
                .DEPTH     (IN_DEPTH)
        ) inBuf (
                .clk    (clk),
                .rst    (rst),
                .push   (inPush),
                .wrData (instr),
                .pop    (move),
                .rdData (inHead),
                .empty  (inEmpty),
                .full   (inFull)
        );

        instrDecoder decoder (
                .instr (inHead),
                .ctrl  (decoded)
        );

        creditFifo #(
                .payload_t (ctrlWord_t),
                .DEPTH     (OUT_DEPTH)
        ) outBuf (
                .clk    (clk),
                .rst    (rst),
                .push   (move),
                .wrData (decoded),
                .pop    (outPop),
                .rdData (outHead),
                .empty  (outEmpty),
                .full   (outFull)
        );

        creditSender sender (
                .clk        (clk),
                .rst        (rst),
                .empty      (outEmpty),
                .head       (outHead),
                .pop        (outPop),
                .ctrlCredit (ctrlCredit),
                .ctrlValid  (ctrlValid),
                .ctrl       (ctrl)
        );

        // One credit back per entry leaving inBuf
        always_ff @(posedge clk)
        begin
                if (rst)
                        instrCredit <= 1'b0;
                else
                        instrCredit <= move;
        end

endmodule

/* tbDecodeUnit.sv */
`timescale 1ns/1ps

module tbDecodeUnit
        import decoderPkg::*;
();

        localparam int NUM_INSTR      = 66;
        localparam int TIMEOUT_CYCLES = NUM_INSTR * 40 + 200;

        logic      clk;
        logic      rst;
        logic      instrValid;
        instr_t    instr;
        logic      instrCredit;
        logic      ctrlValid;
        ctrlWord_t ctrl;
        logic      ctrlCredit;

        ctrlWord_t expQ [$];
        int        upCredits;      // Upstream credits held by the testbench
        int        owed;           // Words received but not yet credited
        int        gotWords;
        int        creditPulses;
        logic      returnCredits;
        string     testName;

        decodeUnit UUT (
                .clk         (clk),
                .rst         (rst),
                .instrValid  (instrValid),
                .instr       (instr),
                .instrCredit (instrCredit),
                .ctrlValid   (ctrlValid),
                .ctrl        (ctrl),
                .ctrlCredit  (ctrlCredit)
        );

        initial
        begin
                clk = 1'b0;
                forever #10 clk = ~clk;
        end

        initial
        begin
                repeat (TIMEOUT_CYCLES) @(posedge clk);
                $display("Watchdog timeout after %0d cycles in test %s", TIMEOUT_CYCLES, testName);
                $display("TESTS FAILED");
                $fatal(1, "simulation hung");
        end

        ////////////////////////////////////////
        // Reference decode

        function automatic memAccess_t memSize(input logic [5:0] op);
                case (op)
                        OP_LW, OP_SW: return MEM_WORD;
                        OP_LH, OP_SH: return MEM_HALF;
                        default:      return MEM_BYTE;
                endcase
        endfunction

        function automatic ctrlWord_t refDecode(input instr_t w);
                ctrlWord_t  c;
                logic [5:0] op;
                logic [5:0] fn;
                op = w[31:26];
                fn = w[5:0];
                c = '0;
                c.memToReg = 1'b1;   // Inactive word routes the ALU result
                if (w == '0)
                        return c;
                case (op)
                        OP_SPECIAL:
                        begin
                                c.regWrite  = 1'b1;
                                c.regDst    = 1'b1;
                                c.shamtSrcA = fn inside {FN_SLL, FN_SRL, FN_SRA};
                                case (fn)
                                        FN_ADD:           c.aluOp = ALU_ADD;
                                        FN_ADDU:          c.aluOp = ALU_ADDU;
                                        FN_SUB:           c.aluOp = ALU_SUB;
                                        FN_AND:           c.aluOp = ALU_AND;
                                        FN_OR:            c.aluOp = ALU_OR;
                                        FN_NOR:           c.aluOp = ALU_NOR;
                                        FN_XOR:           c.aluOp = ALU_XOR;
                                        FN_SLT:           c.aluOp = ALU_SLT;
                                        FN_SLTU:          c.aluOp = ALU_SLTU;
                                        FN_MOVN:          c.aluOp = ALU_MOVN;
                                        FN_MOVZ:          c.aluOp = ALU_MOVZ;
                                        FN_SLL, FN_SLLV:  c.aluOp = ALU_SLL;
                                        FN_SRA, FN_SRAV:  c.aluOp = ALU_SRA;
                                        FN_SRL:           c.aluOp = w[21] ? ALU_ROTR : ALU_SRL;
                                        FN_SRLV:          c.aluOp = w[6] ? ALU_ROTR : ALU_SRL;
                                        default:          c.illegal = 1'b1;
                                endcase
                        end
                        OP_SPECIAL3:
                        begin
                                c.regWrite = 1'b1;
                                c.regDst   = 1'b1;
                                c.aluOp    = (w[10:6] == SP_SEB) ? ALU_SEB : ALU_SEH;
                                c.illegal  = (fn != FN_BSHFL) || !(w[10:6] inside {SP_SEB, SP_SEH});
                        end
                        OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI:
                        begin
                                c.regWrite   = 1'b1;
                                c.immSrcB    = 1'b1;
                                c.zeroExtImm = op inside {OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
                                case (op)
                                        OP_ADDIU: c.aluOp = ALU_ADDU;
                                        OP_SLTI:  c.aluOp = ALU_SLT;
                                        OP_SLTIU: c.aluOp = ALU_SLTU;
                                        OP_ANDI:  c.aluOp = ALU_AND;
                                        OP_ORI:   c.aluOp = ALU_OR;
                                        OP_XORI:  c.aluOp = ALU_XOR;
                                        OP_LUI:   c.aluOp = ALU_LUI;
                                        default:  c.aluOp = ALU_ADD;
                                endcase
                        end
                        OP_LW, OP_LH, OP_LB:
                        begin
                                c.regWrite = 1'b1;
                                c.immSrcB  = 1'b1;
                                c.memToReg = 1'b0;
                                c.memRead  = memSize(op);
                                c.aluOp    = ALU_ADDR;
                        end
                        OP_SW, OP_SH, OP_SB:
                        begin
                                c.immSrcB  = 1'b1;
                                c.memWrite = memSize(op);
                                c.aluOp    = ALU_ADDR;
                        end
                        default: c.illegal = 1'b1;
                endcase
                if (c.illegal)
                begin
                        c = '0;
                        c.memToReg = 1'b1;
                        c.illegal  = 1'b1;
                end
                return c;
        endfunction

        ////////////////////////////////////////
        // Checks and bus handling

        task automatic compareCtrl(input ctrlWord_t expected, input ctrlWord_t actual);
                if (actual !== expected)
                begin
                        $display("ERROR %s: expected %h actual %h", testName, expected, actual);
                        $display("TESTS FAILED");
                        $fatal(1, "control word mismatch");
                end
        endtask

        task automatic compareCount(input string what, input int expected, input int actual);
                if (actual != expected)
                begin
                        $display("ERROR %s: %s expected %0d actual %0d", testName, what, expected,
                                 actual);
                        $display("TESTS FAILED");
                        $fatal(1, "count mismatch");
                end
        endtask

        task automatic sampleOutputs();
                if (instrCredit)
                begin
                        upCredits++;
                        creditPulses++;
                end
                if (ctrlValid && expQ.size() == 0)
                begin
                        $display("Test %s saw a control word with none outstanding", testName);
                        $display("TESTS FAILED");
                        $fatal(1, "unexpected control word");
                end
                else if (ctrlValid)
                begin
                        compareCtrl(expQ.pop_front(), ctrl);
                        gotWords++;
                        owed++;
                end
        endtask

        task automatic driveCredit();
                if (returnCredits && owed > 0)
                begin
                        ctrlCredit = 1'b1;   // One credit back per cycle
                        owed--;
                end
                else
                        ctrlCredit = 1'b0;
        endtask

        task automatic idleCycle();
                @(negedge clk);
                sampleOutputs();
                instrValid = 1'b0;
                driveCredit();
        endtask

        task automatic sendInstr(input instr_t word);
                logic sent;
                sent = 1'b0;
                while (!sent)
                begin
                        @(negedge clk);
                        sampleOutputs();
                        if (upCredits > 0)
                        begin
                                instrValid = 1'b1;
                                instr      = word;
                                upCredits--;
                                expQ.push_back(refDecode(word));
                                sent = 1'b1;
                        end
                        else
                                instrValid = 1'b0;
                        driveCredit();
                end
        endtask

        task automatic drain();
                while (expQ.size() != 0)
                        idleCycle();
                repeat (4) idleCycle();
                compareCount("upstream credits", IN_DEPTH, upCredits);
        endtask

        function automatic logic [4:0] randReg();
                logic [31:0] r;
                r = $urandom;
                return r[4:0];
        endfunction

        function automatic logic [15:0] randImm();
                logic [31:0] r;
                r = $urandom;
                return r[15:0];
        endfunction

        function automatic instr_t rType(input logic [4:0] rs, input logic [4:0] sa,
                                         input logic [5:0] fn);
                return {OP_SPECIAL, rs, randReg(), randReg(), sa, fn};
        endfunction

        function automatic instr_t iType(input logic [5:0] op);
                return {op, randReg(), randReg(), randImm()};
        endfunction

        ////////////////////////////////////////
        // Directed tests

        task automatic testReset();
                int p0;
                testName = "reset";
                p0 = creditPulses;
                repeat (8) idleCycle();
                compareCount("instrCredit pulses", 0, creditPulses - p0);
        endtask

        task automatic testRType();
                logic [5:0] fns [11];
                testName = "rtype";
                fns = '{FN_ADD, FN_ADDU, FN_SUB, FN_AND, FN_OR, FN_NOR, FN_XOR, FN_SLT,
                        FN_SLTU, FN_MOVN, FN_MOVZ};
                foreach (fns[i])
                        sendInstr(rType(randReg(), 5'd0, fns[i]));
                sendInstr(rType(5'd0, randReg(), FN_SLL));
                sendInstr(rType(5'd0, randReg(), FN_SRL));
                sendInstr(rType(5'd1, randReg(), FN_SRL));   // ROTR
                sendInstr(rType(5'd0, randReg(), FN_SRA));
                sendInstr(rType(randReg(), 5'd0, FN_SLLV));
                sendInstr(rType(randReg(), 5'd0, FN_SRLV));
                sendInstr(rType(randReg(), 5'd1, FN_SRLV));  // ROTRV
                sendInstr(rType(randReg(), 5'd0, FN_SRAV));
                sendInstr({OP_SPECIAL3, 5'd0, randReg(), randReg(), SP_SEB, FN_BSHFL});
                sendInstr({OP_SPECIAL3, 5'd0, randReg(), randReg(), SP_SEH, FN_BSHFL});
                drain();
        endtask

        task automatic testImmMem();
                logic [5:0] ops [14];
                testName = "immediate and memory";
                ops = '{OP_ADDI, OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI, OP_SLTI, OP_SLTIU, OP_LUI,
                        OP_LW, OP_LH, OP_LB, OP_SW, OP_SH, OP_SB};
                foreach (ops[i])
                        sendInstr(iType(ops[i]));
                drain();
        endtask

        task automatic testIllegal();
                logic [5:0]  badFns [8];
                logic [5:0]  badOps [7];
                logic [31:0] r;
                testName = "nop and illegal";
                badFns = '{6'b001000, 6'b001001, 6'b010000, 6'b010001, 6'b010010, 6'b010011,
                           6'b011000, 6'b011001};   // JR, JALR, HI/LO moves, MULT
                badOps = '{6'b000001, 6'b000010, 6'b000011, 6'b000100, 6'b000101, 6'b000110,
                           6'b000111};              // Branches and jumps
                sendInstr('0);
                foreach (badFns[i])
                        sendInstr(rType(randReg(), 5'd0, badFns[i]));
                foreach (badOps[i])
                        sendInstr(iType(badOps[i]));
                sendInstr({OP_SPECIAL2, randReg(), randReg(), 5'd0, 5'd0, 6'b000010});  // MUL
                sendInstr({OP_SPECIAL2, randReg(), randReg(), 5'd0, 5'd0, 6'b000000});  // MADD
                r = $urandom;
                sendInstr({2'b11, r[3:0], r[25:0]});   // Unused opcode block
                drain();
        endtask

        task automatic testBackPressure();
                int p0;
                int g0;
                testName = "backpressure";
                returnCredits = 1'b0;
                g0 = gotWords;
                for (int i = 0; i < 12; i++)
                begin
                        case (i % 3)
                                0:       sendInstr(rType(randReg(), 5'd0, FN_SUB));
                                1:       sendInstr(iType(OP_ORI));
                                default: sendInstr(iType(OP_LH));
                        endcase
                end
                repeat (4) idleCycle();
                p0 = creditPulses;
                repeat (16) idleCycle();
                compareCount("words without credit", OUT_CREDITS, gotWords - g0);
                compareCount("instrCredit pulses while stalled", 0, creditPulses - p0);
                compareCount("upstream credits while stalled", 0, upCredits);
                returnCredits = 1'b1;
                drain();
                compareCount("words after credit return", 12, gotWords - g0);
        endtask

        initial
        begin
                void'($urandom(32'h93a3_2ad6));
                rst           = 1'b1;
                instrValid    = 1'b0;
                instr         = '0;
                ctrlCredit    = 1'b0;
                upCredits     = IN_DEPTH;
                owed          = 0;
                gotWords      = 0;
                creditPulses  = 0;
                returnCredits = 1'b1;
                testName      = "init";
                repeat (16) @(negedge clk);
                rst = 1'b0;
                testReset();
                testRType();
                testImmMem();
                testIllegal();
                testBackPressure();
                $display("TESTS PASSED");
                $finish;
        end

endmodule

/* decodeUnit.f */
decoderPkg.sv
creditFifo.sv
instrDecoder.sv
creditSender.sv
decodeUnit.sv
tbDecodeUnit.sv

/* run.sh */
#!/bin/sh
# Build and run the decode unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
        --top-module tbDecodeUnit \
        -f decodeUnit.f \
        -o simDecodeUnit

./obj_dir/simDecodeUnit
